// File: vtp_addr_pkg.sv
/*
 * VTP address formats
 * Page numbers, page table entries and the rule that turns a table page
 * and an index into a memory word address
 */
package vtp_addr_pkg;

    // Page numbers count 4 KB pages
    typedef logic [19:0] t_va_page;
    typedef logic [19:0] t_pa_page;
    typedef logic [31:0] t_pte;
    typedef logic [31:0] t_mem_addr;

    // Low virtual page bits that a 2 MB page passes through
    localparam int BIG_PAGE_SHIFT = 9;

    // Level one uses virtual page bits 19:9 and level two uses bits 8:0
    localparam int L1_INDEX_BITS = 11;
    localparam int L2_INDEX_BITS = 9;

    // Entry fields
    localparam int PTE_PRESENT_BIT = 0;
    localparam int PTE_LEAF_BIT = 1;
    localparam int PTE_PAGE_LSB = 12;

    // One table page holds 1024 entry words
    localparam int TABLE_WORD_BITS = 10;

    // Word address of an entry, table page times 1024 plus index
    function automatic t_mem_addr pte_addr(input t_pa_page tbl_page,
                                           input logic [L1_INDEX_BITS-1:0] index);
        return (t_mem_addr'(tbl_page) << TABLE_WORD_BITS) + t_mem_addr'(index);
    endfunction

endpackage

// File: vtp_svc_pkg.sv
/*
 * VTP service control types
 * State encodings of the controller and the walker, and the event vector
 */
package vtp_svc_pkg;

    // Controller sequencing, one translation in service at a time
    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_LOOKUP,
        CTRL_CHECK,
        CTRL_WALK,
        CTRL_RESPOND,
        CTRL_FLUSH
    } t_ctrl_state;

    // Page table walker steps
    typedef enum logic [2:0] {
        WALK_IDLE,
        WALK_RD_L1,
        WALK_WAIT_L1,
        WALK_RD_L2,
        WALK_WAIT_L2,
        WALK_DONE
    } t_walk_state;

    // Event strobes for statistics counters
    typedef logic [3:0] t_vtp_events;

    localparam int EV_HIT_4KB = 0;
    localparam int EV_HIT_2MB = 1;
    localparam int EV_MISS = 2;
    localparam int EV_FAULT = 3;

endpackage

// File: vtp_tlb_if.sv
/*
 * Controller to TLB connection
 * Carries lookup requests with their hit response, fills and flush
 */
`timescale 1ns/1ps

interface vtp_tlb_if;
    import vtp_addr_pkg::*;

    // Lookup, answered one cycle later on hit and hit_pa
    logic     lookup_en;
    t_va_page lookup_va;
    logic     hit;
    t_pa_page hit_pa;

    // Single cycle fill and flush strobes
    logic     fill_en;
    t_va_page fill_va;
    t_pa_page fill_pa;
    logic     flush;

    modport ctrl (
        output lookup_en, lookup_va, fill_en, fill_va, fill_pa, flush,
        input  hit, hit_pa
    );

    modport tlb (
        input  lookup_en, lookup_va, fill_en, fill_va, fill_pa, flush,
        output hit, hit_pa
    );

endinterface

// File: vtp_walk_if.sv
/*
 * Controller to page table walker connection
 * A start strobe with the virtual page, answered by a done strobe
 */
`timescale 1ns/1ps

interface vtp_walk_if;
    import vtp_addr_pkg::*;

    // Request, only issued while the walker is idle
    logic     start;
    t_va_page va;

    // Result, valid in the cycle of done
    logic     done;
    t_pa_page pa;
    logic     big;
    logic     fault;

    modport ctrl (
        output start, va,
        input  done, pa, big, fault
    );

    modport walker (
        input  start, va,
        output done, pa, big, fault
    );

endinterface

// File: vtp_tlb.sv
/*
 * Direct-mapped TLB
 * Caches translations for one page size, set by PAGE_SHIFT, and answers
 * each lookup one cycle later
 */
`timescale 1ns/1ps

module vtp_tlb
#(
    parameter int PAGE_SHIFT = 0,
    parameter int NUM_SETS = 64
)
(
    input logic clk,
    input logic reset,
    vtp_tlb_if.tlb tlb_if
);
    import vtp_addr_pkg::*;

    localparam int IDX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = $bits(t_va_page) - PAGE_SHIFT - IDX_BITS;
    localparam int PPN_BITS = $bits(t_pa_page) - PAGE_SHIFT;

    // Page bits that pass straight from the virtual page to the result
    localparam t_pa_page LOW_MASK = t_pa_page'((1 << PAGE_SHIFT) - 1);

    typedef logic [IDX_BITS-1:0] t_set_idx;
    typedef logic [TAG_BITS-1:0] t_tag;
    typedef logic [PPN_BITS-1:0] t_ppn_hi;

    logic [NUM_SETS-1:0] valid;
    t_tag                tag_mem [NUM_SETS];
    t_ppn_hi             ppn_mem [NUM_SETS];

    // The set comes from the low bits above the page offset
    function automatic t_set_idx set_of(input t_va_page va);
        t_va_page sh;
        sh = va >> PAGE_SHIFT;
        return sh[IDX_BITS-1:0];
    endfunction

    // The tag is everything above the set index
    function automatic t_tag tag_of(input t_va_page va);
        t_va_page sh;
        sh = va >> PAGE_SHIFT;
        return sh[IDX_BITS +: TAG_BITS];
    endfunction

    // Valid bits, cleared all at once by a flush
    always_ff @(posedge clk)
    begin
        if (reset || tlb_if.flush)
        begin
            valid <= '0;
        end
        else if (tlb_if.fill_en)
        begin
            valid[set_of(tlb_if.fill_va)] <= 1'b1;
        end
    end

    // A fill overwrites whatever the set held before
    always_ff @(posedge clk)
    begin
        if (tlb_if.fill_en)
        begin
            tag_mem[set_of(tlb_if.fill_va)] <= tag_of(tlb_if.fill_va);
            ppn_mem[set_of(tlb_if.fill_va)] <= t_ppn_hi'(tlb_if.fill_pa >> PAGE_SHIFT);
        end
    end

    // Lookup result, registered so it shows one cycle after the request
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tlb_if.hit <= 1'b0;
        end
        else
        begin
            tlb_if.hit <= tlb_if.lookup_en && valid[set_of(tlb_if.lookup_va)] &&
                          (tag_mem[set_of(tlb_if.lookup_va)] == tag_of(tlb_if.lookup_va));
        end
    end

    // Rebuild the full 4 KB page from the stored upper bits
    always_ff @(posedge clk)
    begin
        if (tlb_if.lookup_en)
        begin
            tlb_if.hit_pa <= (t_pa_page'(ppn_mem[set_of(tlb_if.lookup_va)]) << PAGE_SHIFT) |
                             (t_pa_page'(tlb_if.lookup_va) & LOW_MASK);
        end
    end

endmodule

// File: vtp_pt_walker.sv
/*
 * Page table walker
 * Reads the level-one and, when needed, the level-two entry of a virtual
 * page from external memory and reports the page, its size or a fault
 */
`timescale 1ns/1ps

module vtp_pt_walker
(
    input  logic                   clk,
    input  logic                   reset,
    vtp_walk_if.walker             walk,
    input  vtp_addr_pkg::t_pa_page pt_base,

    output logic                    mem_rd_en,
    output vtp_addr_pkg::t_mem_addr mem_rd_addr,
    input  logic                    mem_rd_valid,
    input  vtp_addr_pkg::t_pte      mem_rd_data
);
    import vtp_addr_pkg::*;
    import vtp_svc_pkg::*;

    t_walk_state state;

    // Request and result registers
    t_va_page va_q;
    t_pa_page l2_table;
    t_pa_page pa_q;
    logic     big_q;
    logic     fault_q;

    // Page field of the entry coming back from memory
    t_pa_page rd_page;

    assign rd_page = mem_rd_data[PTE_PAGE_LSB +: $bits(t_pa_page)];

    // ====================
    // Memory reads
    // ====================

    // One read per RD state, so only one is ever outstanding
    always_comb
    begin
        mem_rd_en = (state == WALK_RD_L1) || (state == WALK_RD_L2);
        if (state == WALK_RD_L2)
        begin
            mem_rd_addr = pte_addr(l2_table, L1_INDEX_BITS'(va_q[L2_INDEX_BITS-1:0]));
        end
        else
        begin
            mem_rd_addr = pte_addr(pt_base, va_q[L2_INDEX_BITS +: L1_INDEX_BITS]);
        end
    end

    // ====================
    // Walk sequencing
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= WALK_IDLE;
        end
        else
        begin
            case (state)
                WALK_IDLE:
                    if (walk.start)
                        state <= WALK_RD_L1;
                WALK_RD_L1:
                    state <= WALK_WAIT_L1;
                WALK_WAIT_L1:
                    if (mem_rd_valid)
                    begin
                        // Faults and 2 MB leaves finish at level one
                        if (!mem_rd_data[PTE_PRESENT_BIT] || mem_rd_data[PTE_LEAF_BIT])
                            state <= WALK_DONE;
                        else
                            state <= WALK_RD_L2;
                    end
                WALK_RD_L2:
                    state <= WALK_WAIT_L2;
                WALK_WAIT_L2:
                    if (mem_rd_valid)
                        state <= WALK_DONE;
                default:
                    state <= WALK_IDLE;
            endcase
        end
    end

    // Capture the request and build the result as entries arrive
    always_ff @(posedge clk)
    begin
        if (state == WALK_IDLE && walk.start)
        begin
            va_q <= walk.va;
            big_q <= 1'b0;
            fault_q <= 1'b0;
        end
        else if (state == WALK_WAIT_L1 && mem_rd_valid)
        begin
            l2_table <= rd_page;
            fault_q <= !mem_rd_data[PTE_PRESENT_BIT];
            big_q <= mem_rd_data[PTE_PRESENT_BIT] && mem_rd_data[PTE_LEAF_BIT];
            // A 2 MB page keeps the low virtual page bits
            pa_q <= {rd_page[$bits(t_pa_page)-1:BIG_PAGE_SHIFT], va_q[BIG_PAGE_SHIFT-1:0]};
        end
        else if (state == WALK_WAIT_L2 && mem_rd_valid)
        begin
            fault_q <= !mem_rd_data[PTE_PRESENT_BIT];
            pa_q <= rd_page;
        end
    end

    assign walk.done = (state == WALK_DONE);
    assign walk.pa = pa_q;
    assign walk.big = big_q;
    assign walk.fault = fault_q;

endmodule

// File: vtp_svc_ctrl.sv
/*
 * VTP service controller
 * Holds one request per client port, picks them round-robin, looks them up
 * in both TLBs, starts walks on a miss, fills, responds and flushes
 */
`timescale 1ns/1ps

module vtp_svc_ctrl
#(
    parameter int N_PORTS = 4
)
(
    input  logic                                 clk,
    input  logic                                 reset,

    input  logic [N_PORTS-1:0]                   lookup_en,
    input  vtp_addr_pkg::t_va_page [N_PORTS-1:0] lookup_va,
    output logic [N_PORTS-1:0]                   lookup_rdy,

    output logic [N_PORTS-1:0]                   rsp_valid,
    output vtp_addr_pkg::t_pa_page               rsp_pa,
    output logic                                 rsp_big,
    output logic                                 rsp_fault,

    input  logic                                 tlb_flush,
    output vtp_svc_pkg::t_vtp_events             events,

    vtp_tlb_if.ctrl                              tlb_4kb,
    vtp_tlb_if.ctrl                              tlb_2mb,
    vtp_walk_if.ctrl                             walk
);
    import vtp_addr_pkg::*;
    import vtp_svc_pkg::*;

    localparam int PORT_BITS = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

    typedef logic [PORT_BITS-1:0] t_port_idx;

    t_ctrl_state state;

    logic [N_PORTS-1:0] slot_valid;
    t_va_page           slot_va [N_PORTS];

    t_port_idx prio_ptr;
    t_port_idx pick_idx;
    logic      pick_found;
    t_port_idx sel_idx;
    t_va_page  cur_va;
    logic      flush_pend;
    logic      any_hit;

    // ====================
    // Request slots
    // ====================

    // A port is ready exactly when its slot is empty
    assign lookup_rdy = ~slot_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            slot_valid <= '0;
        end
        else
        begin
            slot_valid <= (slot_valid | lookup_en) & ~rsp_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        for (int p = 0; p < N_PORTS; p++)
        begin
            if (lookup_en[p] && !slot_valid[p])
                slot_va[p] <= lookup_va[p];
        end
    end

    // Search pending slots starting at the rotating priority pointer
    always_comb
    begin : arb
        int cand;
        pick_found = 1'b0;
        pick_idx = prio_ptr;
        for (int i = 0; i < N_PORTS; i++)
        begin
            cand = int'(prio_ptr) + i;
            if (cand >= N_PORTS)
                cand = cand - N_PORTS;
            if (!pick_found && slot_valid[cand])
            begin
                pick_found = 1'b1;
                pick_idx = t_port_idx'(cand);
            end
        end
    end

    // ====================
    // Service sequencing
    // ====================

    assign any_hit = tlb_4kb.hit || tlb_2mb.hit;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= CTRL_IDLE;
            prio_ptr <= '0;
            flush_pend <= 1'b0;
            events <= '0;
        end
        else
        begin
            events <= '0;
            // A flush request waits here until the controller is idle
            flush_pend <= tlb_flush || (flush_pend && state != CTRL_FLUSH);
            case (state)
                CTRL_IDLE:
                    if (flush_pend)
                        state <= CTRL_FLUSH;
                    else if (pick_found)
                    begin
                        state <= CTRL_LOOKUP;
                        if (pick_idx == t_port_idx'(N_PORTS - 1))
                            prio_ptr <= '0;
                        else
                            prio_ptr <= pick_idx + 1'b1;
                    end
                CTRL_LOOKUP:
                    state <= CTRL_CHECK;
                CTRL_CHECK:
                begin
                    events[EV_HIT_4KB] <= tlb_4kb.hit;
                    events[EV_HIT_2MB] <= !tlb_4kb.hit && tlb_2mb.hit;
                    events[EV_MISS] <= !any_hit;
                    state <= any_hit ? CTRL_RESPOND : CTRL_WALK;
                end
                CTRL_WALK:
                    if (walk.done)
                    begin
                        events[EV_FAULT] <= walk.fault;
                        state <= CTRL_RESPOND;
                    end
                default:
                    state <= CTRL_IDLE;
            endcase
        end
    end

    // Selected request and the response it will get
    always_ff @(posedge clk)
    begin
        if (state == CTRL_IDLE && pick_found)
        begin
            sel_idx <= pick_idx;
            cur_va <= slot_va[pick_idx];
        end
        if (state == CTRL_CHECK)
        begin
            rsp_pa <= tlb_4kb.hit ? tlb_4kb.hit_pa : tlb_2mb.hit_pa;
            rsp_big <= !tlb_4kb.hit;
            rsp_fault <= 1'b0;
        end
        else if (state == CTRL_WALK && walk.done)
        begin
            rsp_pa <= walk.pa;
            rsp_big <= walk.big;
            rsp_fault <= walk.fault;
        end
    end

    // ====================
    // TLB, walker and response strobes
    // ====================

    always_comb
    begin
        tlb_4kb.lookup_en = (state == CTRL_LOOKUP);
        tlb_2mb.lookup_en = (state == CTRL_LOOKUP);
        tlb_4kb.lookup_va = cur_va;
        tlb_2mb.lookup_va = cur_va;

        // A completed walk fills only the TLB of its page size
        tlb_4kb.fill_en = (state == CTRL_WALK) && walk.done && !walk.fault && !walk.big;
        tlb_2mb.fill_en = (state == CTRL_WALK) && walk.done && !walk.fault && walk.big;
        tlb_4kb.fill_va = cur_va;
        tlb_2mb.fill_va = cur_va;
        tlb_4kb.fill_pa = walk.pa;
        tlb_2mb.fill_pa = walk.pa;

        tlb_4kb.flush = (state == CTRL_FLUSH);
        tlb_2mb.flush = (state == CTRL_FLUSH);

        walk.start = (state == CTRL_CHECK) && !any_hit;
        walk.va = cur_va;

        rsp_valid = '0;
        if (state == CTRL_RESPOND)
            rsp_valid[sel_idx] = 1'b1;
    end

endmodule

// File: vtp_svc.sv
/*
 * VTP translation service top level
 * Joins the controller, the 4 KB and 2 MB TLBs and the page table walker
 */
`timescale 1ns/1ps

module vtp_svc
#(
    parameter int N_PORTS = 4,
    parameter int TLB_4KB_SETS = 64,
    parameter int TLB_2MB_SETS = 16
)
(
    input  logic                                 clk,
    input  logic                                 reset,

    // Client requests
    input  logic [N_PORTS-1:0]                   lookup_en,
    input  vtp_addr_pkg::t_va_page [N_PORTS-1:0] lookup_va,
    output logic [N_PORTS-1:0]                   lookup_rdy,

    // Responses, shared payload with a strobe per port
    output logic [N_PORTS-1:0]                   rsp_valid,
    output vtp_addr_pkg::t_pa_page               rsp_pa,
    output logic                                 rsp_big,
    output logic                                 rsp_fault,

    // Page table memory reads
    output logic                                 mem_rd_en,
    output vtp_addr_pkg::t_mem_addr              mem_rd_addr,
    input  logic                                 mem_rd_valid,
    input  vtp_addr_pkg::t_pte                   mem_rd_data,

    input  vtp_addr_pkg::t_pa_page               pt_base,
    input  logic                                 tlb_flush,
    output vtp_svc_pkg::t_vtp_events             events
);
    import vtp_addr_pkg::*;

    vtp_tlb_if  tlb_4kb_bus ();
    vtp_tlb_if  tlb_2mb_bus ();
    vtp_walk_if walk_bus ();

    vtp_svc_ctrl #(.N_PORTS(N_PORTS)) ctrl (
        .clk(clk),
        .reset(reset),
        .lookup_en(lookup_en),
        .lookup_va(lookup_va),
        .lookup_rdy(lookup_rdy),
        .rsp_valid(rsp_valid),
        .rsp_pa(rsp_pa),
        .rsp_big(rsp_big),
        .rsp_fault(rsp_fault),
        .tlb_flush(tlb_flush),
        .events(events),
        .tlb_4kb(tlb_4kb_bus.ctrl),
        .tlb_2mb(tlb_2mb_bus.ctrl),
        .walk(walk_bus.ctrl)
    );

    // The 2 MB TLB ignores the low virtual page bits of a big page
    vtp_tlb #(.PAGE_SHIFT(0), .NUM_SETS(TLB_4KB_SETS)) tlb_4kb (
        .clk(clk),
        .reset(reset),
        .tlb_if(tlb_4kb_bus.tlb)
    );

    vtp_tlb #(.PAGE_SHIFT(BIG_PAGE_SHIFT), .NUM_SETS(TLB_2MB_SETS)) tlb_2mb (
        .clk(clk),
        .reset(reset),
        .tlb_if(tlb_2mb_bus.tlb)
    );

    vtp_pt_walker walker (
        .clk(clk),
        .reset(reset),
        .walk(walk_bus.walker),
        .pt_base(pt_base),
        .mem_rd_en(mem_rd_en),
        .mem_rd_addr(mem_rd_addr),
        .mem_rd_valid(mem_rd_valid),
        .mem_rd_data(mem_rd_data)
    );

endmodule

// File: tb_vtp_svc.sv
/*
 * VTP translation service testbench
 * Directed tests against a page table memory model with random read latency
 * and a reference walk of the same table
 */
`timescale 1ns/1ps

module tb_vtp_svc;
    import vtp_addr_pkg::*;
    import vtp_svc_pkg::*;

    localparam int N_PORTS = 4;
    localparam int TIMEOUT = 200;
    localparam int SEED = 73688;
    localparam t_pa_page PT_BASE = 20'h00010;

    // Pages used by the tests
    localparam t_va_page VA_SMALL = 20'h12345;
    localparam t_va_page VA_BIG_A = 20'h40255;
    localparam t_va_page VA_BIG_B = 20'h40312;
    localparam t_va_page VA_L1_FAULT = 20'h55000;
    localparam t_va_page VA_L2_FAULT = 20'h12346;

    logic                   clk = 1'b0;
    logic                   reset;
    logic [N_PORTS-1:0]     lookup_en;
    t_va_page [N_PORTS-1:0] lookup_va;
    logic [N_PORTS-1:0]     lookup_rdy;
    logic [N_PORTS-1:0]     rsp_valid;
    t_pa_page               rsp_pa;
    logic                   rsp_big;
    logic                   rsp_fault;
    logic                   mem_rd_en;
    t_mem_addr              mem_rd_addr;
    logic                   mem_rd_valid;
    t_pte                   mem_rd_data;
    t_pa_page               pt_base;
    logic                   tlb_flush;
    t_vtp_events            events;

    // Page table memory, words never written read back as zero
    t_pte pt_mem [t_mem_addr];

    int error_count = 0;
    int test_count = 0;

    // Running counts of event pulses and memory reads, with a mark per test
    int ev_count [4];
    int ev_mark [4];
    int rd_count = 0;
    int rd_mark = 0;

    t_mem_addr rd_addr;
    int        rd_latency;

    vtp_svc #(.N_PORTS(N_PORTS)) i_dut (
        .clk(clk),
        .reset(reset),
        .lookup_en(lookup_en),
        .lookup_va(lookup_va),
        .lookup_rdy(lookup_rdy),
        .rsp_valid(rsp_valid),
        .rsp_pa(rsp_pa),
        .rsp_big(rsp_big),
        .rsp_fault(rsp_fault),
        .mem_rd_en(mem_rd_en),
        .mem_rd_addr(mem_rd_addr),
        .mem_rd_valid(mem_rd_valid),
        .mem_rd_data(mem_rd_data),
        .pt_base(pt_base),
        .tlb_flush(tlb_flush),
        .events(events)
    );

    always #5 clk = ~clk;

    // ====================
    // Memory model
    // ====================

    function automatic t_pte mem_word(input t_mem_addr addr);
        if (pt_mem.exists(addr))
            return pt_mem[addr];
        else
            return '0;
    endfunction

    // Each read is answered once, 1 to 5 cycles after it was seen
    initial
    begin : mem_model
        void'($urandom(SEED));
        mem_rd_valid = 1'b0;
        mem_rd_data = '0;
        forever
        begin
            @(posedge clk);
            if (mem_rd_en === 1'b1)
            begin
                rd_addr = mem_rd_addr;
                rd_latency = 1 + ($urandom % 5);
                repeat (rd_latency - 1) @(posedge clk);
                @(negedge clk);
                mem_rd_valid = 1'b1;
                mem_rd_data = mem_word(rd_addr);
                @(negedge clk);
                mem_rd_valid = 1'b0;
            end
        end
    end

    always @(posedge clk)
    begin
        if (mem_rd_en === 1'b1)
            rd_count++;
        for (int b = 0; b < 4; b++)
        begin
            if (events[b] === 1'b1)
                ev_count[b]++;
        end
    end

    // ====================
    // Reference page table
    // ====================

    // Entry word address is table page times 1024 plus index
    function automatic t_mem_addr l1_word(input t_va_page va);
        return t_mem_addr'(PT_BASE) * 1024 + t_mem_addr'(va[19:9]);
    endfunction

    function automatic t_mem_addr l2_word(input t_pa_page tbl_page, input t_va_page va);
        return t_mem_addr'(tbl_page) * 1024 + t_mem_addr'(va[8:0]);
    endfunction

    function automatic void map_small(input t_va_page va, input t_pa_page tbl_page,
                                      input t_pa_page pa);
        pt_mem[l1_word(va)] = {tbl_page, 12'h001};
        pt_mem[l2_word(tbl_page, va)] = {pa, 12'h001};
    endfunction

    // Present and leaf at level one make a 2 MB page
    function automatic void map_big(input t_va_page va, input t_pa_page pa);
        pt_mem[l1_word(va)] = {pa, 12'h003};
    endfunction

    function automatic void predict(input t_va_page va, output t_pa_page pa,
                                    output logic big, output logic fault);
        t_pte e1;
        t_pte e2;
        e1 = mem_word(l1_word(va));
        pa = '0;
        big = 1'b0;
        fault = 1'b0;
        if (!e1[0])
        begin
            fault = 1'b1;
        end
        else if (e1[1])
        begin
            big = 1'b1;
            pa = {e1[31:21], va[8:0]};
        end
        else
        begin
            e2 = mem_word(l2_word(e1[31:12], va));
            fault = !e2[0];
            pa = e2[31:12];
        end
    endfunction

    // ====================
    // Check helpers
    // ====================

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%0h expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_rsp(input t_va_page va);
        t_pa_page exp_pa;
        logic     exp_big;
        logic     exp_fault;
        predict(va, exp_pa, exp_big, exp_fault);
        compare("rsp_fault", rsp_fault, exp_fault);
        // The page and size carry no meaning on a fault
        if (!exp_fault)
        begin
            compare("rsp_pa", rsp_pa, exp_pa);
            compare("rsp_big", rsp_big, exp_big);
        end
    endtask

    function automatic void mark_counts();
        ev_mark = ev_count;
        rd_mark = rd_count;
    endfunction

    function automatic int ev_delta(input int b);
        return ev_count[b] - ev_mark[b];
    endfunction

    task automatic report_test(input string name, input int err_before);
        test_count++;
        if (error_count == err_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d check(s) wrong", name, error_count - err_before);
    endtask

    // One request on one port, checked against the reference walk
    task automatic translate(input int port, input t_va_page va);
        int n;
        n = 0;
        while (!lookup_rdy[port] && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!lookup_rdy[port])
        begin
            $display("Port %0d stayed busy and never took a request", port);
            error_count++;
        end
        else
        begin
            lookup_en[port] = 1'b1;
            lookup_va[port] = va;
            @(negedge clk);
            lookup_en[port] = 1'b0;
            n = 0;
            while (!rsp_valid[port] && n < TIMEOUT)
            begin
                @(negedge clk);
                n++;
            end
            if (!rsp_valid[port])
            begin
                $display("Timed out waiting for a response on port %0d", port);
                error_count++;
            end
            else
            begin
                check_rsp(va);
                // Events and the ready flag settle one cycle after the response
                @(negedge clk);
                compare("lookup_rdy", lookup_rdy, {N_PORTS{1'b1}});
            end
        end
    endtask

    // ====================
    // Directed tests
    // ====================

    task automatic check_reset_state();
        int err_before;
        err_before = error_count;
        compare("lookup_rdy", lookup_rdy, {N_PORTS{1'b1}});
        compare("rsp_valid", rsp_valid, 0);
        compare("mem_rd_en", mem_rd_en, 0);
        compare("events", events, 0);
        report_test("reset state", err_before);
    endtask

    task automatic small_page_miss_then_hit();
        int err_before;
        err_before = error_count;
        mark_counts();
        translate(0, VA_SMALL);
        compare("miss events", ev_delta(EV_MISS), 1);
        compare("hit_4kb events", ev_delta(EV_HIT_4KB), 0);
        mark_counts();
        translate(0, VA_SMALL);
        compare("hit_4kb events", ev_delta(EV_HIT_4KB), 1);
        compare("mem_rd_en count", rd_count - rd_mark, 0);
        report_test("4 KB miss then hit", err_before);
    endtask

    task automatic big_page_region();
        int err_before;
        err_before = error_count;
        mark_counts();
        translate(2, VA_BIG_A);
        compare("rsp_big", rsp_big, 1);
        compare("miss events", ev_delta(EV_MISS), 1);
        // Another page of the same 2 MB region
        mark_counts();
        translate(3, VA_BIG_B);
        compare("hit_2mb events", ev_delta(EV_HIT_2MB), 1);
        compare("mem_rd_en count", rd_count - rd_mark, 0);
        report_test("2 MB leaf and region hit", err_before);
    endtask

    task automatic fault_not_cached();
        int err_before;
        t_va_page va [2];
        err_before = error_count;
        va[0] = VA_L1_FAULT;
        va[1] = VA_L2_FAULT;
        for (int i = 0; i < 2; i++)
        begin
            for (int rep = 0; rep < 2; rep++)
            begin
                mark_counts();
                translate(1, va[i]);
                compare("rsp_fault", rsp_fault, 1);
                compare("fault events", ev_delta(EV_FAULT), 1);
                if (rd_count == rd_mark)
                begin
                    $display("Faulting page 0x%05h was answered without a table read", va[i]);
                    error_count++;
                end
            end
        end
        report_test("faults are not cached", err_before);
    endtask

    task automatic four_ports_at_once();
        int       err_before;
        int       n;
        int       done_ports;
        int       got [N_PORTS];
        t_va_page va [N_PORTS];
        err_before = error_count;
        done_ports = 0;
        n = 0;
        for (int p = 0; p < N_PORTS; p++)
        begin
            got[p] = 0;
            va[p] = t_va_page'(20'h30001 + p);
        end
        while (lookup_rdy != {N_PORTS{1'b1}} && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (lookup_rdy != {N_PORTS{1'b1}})
        begin
            $display("Ports never became ready together before the joint request");
            error_count++;
        end
        for (int p = 0; p < N_PORTS; p++)
            lookup_va[p] = va[p];
        lookup_en = {N_PORTS{1'b1}};
        @(negedge clk);
        lookup_en = '0;
        n = 0;
        while (done_ports < N_PORTS && n < TIMEOUT)
        begin
            for (int p = 0; p < N_PORTS; p++)
            begin
                if (rsp_valid[p])
                begin
                    got[p]++;
                    done_ports++;
                    check_rsp(va[p]);
                end
            end
            @(negedge clk);
            n++;
        end
        if (done_ports < N_PORTS)
        begin
            $display("Timed out with only %0d of %0d ports answered", done_ports, N_PORTS);
            error_count++;
        end
        compare("lookup_rdy", lookup_rdy, {N_PORTS{1'b1}});
        // No port may see a second strobe afterwards
        repeat (4)
        begin
            if (rsp_valid != '0)
            begin
                $display("Unexpected extra response strobe 0x%0h", rsp_valid);
                error_count++;
            end
            @(negedge clk);
        end
        for (int p = 0; p < N_PORTS; p++)
            compare($sformatf("rsp_valid[%0d] count", p), got[p], 1);
        report_test("four ports at once", err_before);
    endtask

    task automatic flush_clears_tlbs();
        int err_before;
        err_before = error_count;
        mark_counts();
        translate(0, VA_SMALL);
        if (rd_count != rd_mark)
        begin
            $display("Page 0x%05h did not hit before the flush", VA_SMALL);
            error_count++;
        end
        tlb_flush = 1'b1;
        @(negedge clk);
        tlb_flush = 1'b0;
        mark_counts();
        translate(1, VA_SMALL);
        compare("miss events", ev_delta(EV_MISS), 1);
        if (rd_count == rd_mark)
        begin
            $display("Page 0x%05h still hit after the flush", VA_SMALL);
            error_count++;
        end
        // The 2 MB region cached earlier must be gone as well
        mark_counts();
        translate(2, VA_BIG_B);
        compare("miss events", ev_delta(EV_MISS), 1);
        compare("hit_2mb events", ev_delta(EV_HIT_2MB), 0);
        report_test("flush clears both TLBs", err_before);
    endtask

    // ====================
    // Run
    // ====================

    initial
    begin
        reset = 1'b1;
        lookup_en = '0;
        lookup_va = '0;
        pt_base = PT_BASE;
        tlb_flush = 1'b0;

        map_small(VA_SMALL, 20'h00020, 20'hABCDE);
        map_big(VA_BIG_A, 20'h7F9FF);
        for (int p = 0; p < N_PORTS; p++)
            map_small(t_va_page'(20'h30001 + p), 20'h00021, t_pa_page'(20'h11110 + p));

        repeat (3) @(negedge clk);
        reset = 1'b0;

        check_reset_state();
        small_page_miss_then_hit();
        big_page_region();
        fault_not_cached();
        four_ports_at_once();
        flush_clears_tlbs();

        $display("Tests run: %0d, failed checks: %0d", test_count, error_count);
        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: src.f
vtp_addr_pkg.sv
vtp_svc_pkg.sv
vtp_tlb_if.sv
vtp_walk_if.sv
vtp_tlb.sv
vtp_pt_walker.sv
vtp_svc_ctrl.sv
vtp_svc.sv
tb_vtp_svc.sv
